/* Makefile */
.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f build.f --top-module icache_tb
	@out="$$(./obj_dir/Vicache_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

/* build.f */
src/icache_pkg.sv
src/simple_dual_ram.sv
src/icache_way.sv
src/way_select.sv
src/icache_ctrl.sv
src/icache_top.sv
verification/icache_tb.sv

/* src/icache_ctrl.sv */
`timescale 1ns/100ps

module icache_ctrl (
    input  logic                                clk,
    input  logic                                hit_success,
    // fetch front end
    input  logic                                valid,
    input  logic [icache_pkg::ADDR_W-1:0]       addr,
    output logic                                addr_ok,
    output logic                                data_ok,
    output icache_pkg::word_t                   rdata,
    output logic                                cache_miss,
    // lookup side of the ways
    input  logic                                hit,
    input  icache_pkg::way_sel_t                hit_way,
    input  icache_pkg::word_t                   hit_word,
    output logic                                read_en,
    output icache_pkg::index_t                  read_index,
    output icache_pkg::tag_t                    lookup_tag,
    output logic [icache_pkg::OFFSET_W-1:0]     lookup_offset,
    // fill side of the ways
    output logic [icache_pkg::NUM_WAYS-1:0]     fill_en,
    output icache_pkg::index_t                  fill_index,
    output icache_pkg::tag_t                    fill_tag,
    output icache_pkg::line_t                   fill_line,
    // memory bus
    output logic                                rd_req,
    output logic [icache_pkg::ADDR_W-1:0]       rd_addr,
    input  logic                                rd_rdy,
    input  logic                                ret_valid,
    input  logic                                ret_last,
    input  icache_pkg::word_t                   ret_data
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        ASK_MEM,
        REFILL,
        RESPOND
    } state_t;

    state_t state_q;
    state_t state_d;

    logic [ADDR_W-1:0]          addr_q;     // accepted fetch address
    index_t                     buf_index;
    word_t [WORDS_PER_LINE-2:0] beats_q;    // first three beats of a refill
    way_sel_t [SETS-1:0]        lru_q;      // way to replace next, per set
    way_sel_t                   victim;
    logic                       lookup_hit;
    logic                       fill_now;

    //////////////////////////////////////////////////////////////////////
    // front handshake and request buffer
    //////////////////////////////////////////////////////////////////////

    assign addr_ok    = valid && (state_q == IDLE);
    assign read_en    = addr_ok;    // ways read at the accepting edge
    assign read_index = addr[OFFSET_W +: INDEX_W];

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            addr_q <= addr;
        end
    end

    assign buf_index     = addr_q[OFFSET_W +: INDEX_W];
    assign lookup_tag    = addr_q[ADDR_W-1 -: TAG_W];
    assign lookup_offset = addr_q[OFFSET_W-1:0];

    assign lookup_hit = (state_q == LOOKUP) && hit;
    assign cache_miss = (state_q == LOOKUP) && !hit;   // one cycle pulse

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (valid) state_d = LOOKUP;
            LOOKUP:  state_d = hit ? RESPOND : ASK_MEM;
            ASK_MEM: if (rd_rdy) state_d = REFILL;
            REFILL:  if (ret_valid && ret_last) state_d = RESPOND;
            RESPOND: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge hit_success) begin
        if (hit_success) begin
            state_q <= IDLE;
            data_ok <= 1'b0;
        end else begin
            state_q <= state_d;
            data_ok <= (state_d == RESPOND);  // high for the respond cycle
        end
    end

    // returned word, from the hit way or from the line just collected
    always_ff @(posedge clk) begin
        if (lookup_hit) begin
            rdata <= hit_word;
        end else if (fill_now) begin
            rdata <= fill_line[lookup_offset[OFFSET_W-1:2]];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // memory read and refill
    //////////////////////////////////////////////////////////////////////

    assign rd_req  = (state_q == ASK_MEM);
    assign rd_addr = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};  // line aligned

    // beats come in word order, shift down so word 0 ends lowest
    always_ff @(posedge clk) begin
        if ((state_q == REFILL) && ret_valid) begin
            beats_q <= {ret_data, beats_q[WORDS_PER_LINE-2:1]};
        end
    end

    // the last beat goes straight into the fill
    assign fill_now   = (state_q == REFILL) && ret_valid && ret_last;
    assign fill_line  = {ret_data, beats_q};
    assign fill_index = buf_index;
    assign fill_tag   = lookup_tag;
    assign victim     = lru_q[buf_index];

    always_comb begin
        fill_en = '0;
        if (fill_now) begin
            fill_en[victim] = 1'b1;
        end
    end

    // point the set at the way not just used
    always_ff @(posedge clk or posedge hit_success) begin
        if (hit_success) begin
            lru_q <= '0;
        end else if (lookup_hit) begin
            lru_q[buf_index] <= ~hit_way;
        end else if (fill_now) begin
            lru_q[buf_index] <= ~victim;
        end
    end

endmodule

/* src/icache_pkg.sv */
package icache_pkg;

    //////////////////////////////////////////////////////////////////////
    // address geometry
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W   = 32;
    localparam int TAG_W    = 20;   // addr[31:12]
    localparam int INDEX_W  = 8;    // addr[11:4]
    localparam int OFFSET_W = 4;    // addr[3:0], byte within line

    localparam int SETS           = 1 << INDEX_W;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_WAYS       = 2;

    //////////////////////////////////////////////////////////////////////
    // shared types
    //////////////////////////////////////////////////////////////////////

    // one instruction word
    typedef logic [31:0] word_t;

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // word 0 sits in the low bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    // way number, one bit for two ways
    typedef logic [$clog2(NUM_WAYS)-1:0] way_sel_t;

endpackage

/* src/icache_top.sv */
`timescale 1ns/100ps

module icache_top (
    input  logic                          clk,
    input  logic                          hit_success,
    // fetch front end
    input  logic                          valid,
    input  logic [icache_pkg::ADDR_W-1:0] addr,
    output logic                          addr_ok,
    output logic                          data_ok,
    output icache_pkg::word_t             rdata,
    output logic                          cache_miss,
    // memory bus
    output logic                          rd_req,
    output logic [icache_pkg::ADDR_W-1:0] rd_addr,
    input  logic                          rd_rdy,
    input  logic                          ret_valid,
    input  logic                          ret_last,
    input  icache_pkg::word_t             ret_data
);
    import icache_pkg::*;

    // controller to ways
    logic                  read_en;
    index_t                read_index;
    logic [NUM_WAYS-1:0]   fill_en;
    index_t                fill_index;
    tag_t                  fill_tag;
    line_t                 fill_line;

    // ways to selector
    tag_t  [NUM_WAYS-1:0]  way_tag;
    line_t [NUM_WAYS-1:0]  way_line;
    logic  [NUM_WAYS-1:0]  way_valid;

    // selector and controller
    tag_t                  lookup_tag;
    logic [OFFSET_W-1:0]   lookup_offset;
    logic                  hit;
    way_sel_t              hit_way;
    word_t                 hit_word;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .hit_success   (hit_success),
        .valid         (valid),
        .addr          (addr),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rdata         (rdata),
        .cache_miss    (cache_miss),
        .hit           (hit),
        .hit_way       (hit_way),
        .hit_word      (hit_word),
        .read_en       (read_en),
        .read_index    (read_index),
        .lookup_tag    (lookup_tag),
        .lookup_offset (lookup_offset),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .fill_line     (fill_line),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_rdy        (rd_rdy),
        .ret_valid     (ret_valid),
        .ret_last      (ret_last),
        .ret_data      (ret_data)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        icache_way u_way (
            .clk         (clk),
            .hit_success (hit_success),
            .read_en     (read_en),
            .index       (read_index),
            .fill_en     (fill_en[w]),
            .fill_index  (fill_index),
            .fill_tag    (fill_tag),
            .fill_line   (fill_line),
            .way_tag     (way_tag[w]),
            .way_line    (way_line[w]),
            .way_valid   (way_valid[w])
        );
    end

    way_select u_select (
        .way_tag       (way_tag),
        .way_line      (way_line),
        .way_valid     (way_valid),
        .lookup_tag    (lookup_tag),
        .lookup_offset (lookup_offset),
        .hit           (hit),
        .hit_way       (hit_way),
        .hit_word      (hit_word)
    );

endmodule

/* src/icache_way.sv */
`timescale 1ns/100ps

module icache_way (
    input  logic               clk,
    input  logic               hit_success,
    // lookup read
    input  logic               read_en,
    input  icache_pkg::index_t index,
    // line fill
    input  logic               fill_en,
    input  icache_pkg::index_t fill_index,
    input  icache_pkg::tag_t   fill_tag,
    input  icache_pkg::line_t  fill_line,
    // contents of the set read last
    output icache_pkg::tag_t   way_tag,
    output icache_pkg::line_t  way_line,
    output logic               way_valid
);
    import icache_pkg::*;

    logic [SETS-1:0] valid_q;   // one bit per set

    simple_dual_ram #(.entry_t(tag_t)) u_tag_ram (
        .clk        (clk),
        .read_en    (read_en),
        .read_addr  (index),
        .write_en   (fill_en),
        .write_addr (fill_index),
        .write_data (fill_tag),
        .read_data  (way_tag)
    );

    simple_dual_ram #(.entry_t(line_t)) u_line_ram (
        .clk        (clk),
        .read_en    (read_en),
        .read_addr  (index),
        .write_en   (fill_en),
        .write_addr (fill_index),
        .write_data (fill_line),
        .read_data  (way_line)
    );

    // valid bits are read on the same edge as the RAMs
    always_ff @(posedge clk or posedge hit_success) begin
        if (hit_success) begin
            valid_q   <= '0;
            way_valid <= 1'b0;
        end else begin
            if (fill_en) begin
                valid_q[fill_index] <= 1'b1;
            end
            if (read_en) begin
                way_valid <= valid_q[index];    // old bit if filled now
            end
        end
    end

endmodule

/* src/simple_dual_ram.sv */
`timescale 1ns/100ps

module simple_dual_ram #(
    parameter type entry_t = icache_pkg::word_t
) (
    input  logic               clk,
    input  logic               read_en,
    input  icache_pkg::index_t read_addr,
    input  logic               write_en,
    input  icache_pkg::index_t write_addr,
    input  entry_t             write_data,
    output entry_t             read_data
);
    import icache_pkg::*;

    entry_t mem [SETS];

    // write port
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // registered read, old entry on a same-index collision
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

/* src/way_select.sv */
`timescale 1ns/100ps

module way_select (
    input  icache_pkg::tag_t  [icache_pkg::NUM_WAYS-1:0] way_tag,
    input  icache_pkg::line_t [icache_pkg::NUM_WAYS-1:0] way_line,
    input  logic              [icache_pkg::NUM_WAYS-1:0] way_valid,
    input  icache_pkg::tag_t                             lookup_tag,
    input  logic              [icache_pkg::OFFSET_W-1:0] lookup_offset,
    output logic                                         hit,
    output icache_pkg::way_sel_t                         hit_way,
    output icache_pkg::word_t                            hit_word
);
    import icache_pkg::*;

    logic [NUM_WAYS-1:0] match;

    // tag compare per way
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = way_valid[w] && (way_tag[w] == lookup_tag);
        end
    end

    // walk downward so the lowest matching way is the one kept
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit     = 1'b1;
                hit_way = way_sel_t'(w);
            end
        end
    end

    // word select by offset bits 3:2
    assign hit_word = way_line[hit_way][lookup_offset[OFFSET_W-1:2]];

endmodule

/* verification/icache_tb.sv */
`timescale 1ns/100ps

module icache_tb;
    import icache_pkg::*;

    localparam int RANDOM_REQS    = 300;
    localparam int TOTAL_REQS     = 1 + 4 + 5 + RANDOM_REQS + 6;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_REQS + 200;

    logic              clk = 1'b0;
    logic              hit_success;
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic              addr_ok;
    logic              data_ok;
    word_t             rdata;
    logic              cache_miss;
    logic              rd_req;
    logic [ADDR_W-1:0] rd_addr;
    logic              rd_rdy;
    logic              ret_valid;
    logic              ret_last;
    word_t             ret_data;

    logic [15:0] lfsr_state      = 16'd51;
    int          cycle_count     = 0;
    int          error_count     = 0;
    int          errors_at_start = 0;
    int          tests_passed    = 0;
    int          tests_failed    = 0;

    // reference cache with the DUT geometry
    tag_t model_tag   [NUM_WAYS][SETS];
    logic model_valid [NUM_WAYS][SETS];
    logic model_lru   [SETS];

    icache_top dut (
        .clk         (clk),
        .hit_success (hit_success),
        .valid       (valid),
        .addr        (addr),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .cache_miss  (cache_miss),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // random source and memory contents
    //////////////////////////////////////////////////////////////////////

    // taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    // rotate left by 7 then xor
    function automatic word_t mem_word(input logic [ADDR_W-1:0] a);
        return {a[24:0], a[31:25]} ^ 32'h5A5A5A5A;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic void model_reset();
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_valid[w][s] = 1'b0;
                model_tag[w][s]   = '0;
            end
            model_lru[s] = 1'b0;
        end
    endfunction

    // predicts hit or miss and updates tags and lru
    function automatic logic model_access(input logic [ADDR_W-1:0] a);
        index_t idx;
        tag_t   t;
        int     way;
        logic   victim;
        logic   result;
        idx = a[11:4];
        t   = a[31:12];
        way = -1;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (model_valid[w][idx] && model_tag[w][idx] == t) begin
                way = w;    // lowest way wins
            end
        end
        if (way >= 0) begin
            model_lru[idx] = (way == 0);
            result = 1'b1;
        end else begin
            victim = model_lru[idx];
            model_tag[victim][idx]   = t;
            model_valid[victim][idx] = 1'b1;
            model_lru[idx]           = ~victim;
            result = 1'b0;
        end
        return result;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // front end driver and checks
    //////////////////////////////////////////////////////////////////////

    // called and returns 1 ns after a rising edge
    task automatic fetch(input logic [ADDR_W-1:0] a, output logic got_hit);
        logic              exp_hit;
        logic              saw_miss;
        logic              saw_req;
        logic              done;
        int                lat;
        int                wait_cycles;
        int                req_cycle;
        logic [ADDR_W-1:0] req_addr;
        word_t             got_word;
        exp_hit     = model_access(a);
        saw_miss    = 1'b0;
        saw_req     = 1'b0;
        done        = 1'b0;
        lat         = 0;
        wait_cycles = 0;
        req_cycle   = 0;
        req_addr    = '0;
        got_word    = '0;
        valid = 1'b1;
        addr  = a;
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
            wait_cycles++;
        end
        #1;
        valid = 1'b0;
        addr  = '0;
        // the cache is idle here, so the request is taken at once
        if (wait_cycles != 0) begin
            $display("CHECK FAILED at %t: addr_ok for %h came %0d cycles late",
                     $time, a, wait_cycles);
            error_count++;
        end
        while (!done) begin
            @(posedge clk);
            lat++;  // cycles since addr_ok
            if (cache_miss) saw_miss = 1'b1;
            if (rd_req && !saw_req) begin
                saw_req   = 1'b1;
                req_cycle = lat;
                req_addr  = rd_addr;
            end
            if (data_ok) begin
                done     = 1'b1;
                got_word = rdata;
            end
        end
        #1;
        got_hit = !saw_miss;
        if (saw_miss == exp_hit) begin
            $display("CHECK FAILED at %t: addr %h miss=%0b, model hit=%0b",
                     $time, a, saw_miss, exp_hit);
            error_count++;
        end
        if (exp_hit && (saw_req || lat != 2)) begin
            $display("CHECK FAILED at %t: hit on %h took %0d cycles, rd_req=%0b",
                     $time, a, lat, saw_req);
            error_count++;
        end
        if (!exp_hit && (!saw_req || req_cycle != 2 || req_addr != {a[31:4], 4'h0})) begin
            $display("CHECK FAILED at %t: miss on %h gave rd_req in cycle %0d at %h",
                     $time, a, req_cycle, req_addr);
            error_count++;
        end
        if (got_word !== mem_word(a)) begin
            $display("CHECK FAILED at %t: rdata for %h is %h, expected %h",
                     $time, a, got_word, mem_word(a));
            error_count++;
        end
    endtask

    task automatic expect_outcome(input logic got_hit, input logic want_hit,
                                  input logic [ADDR_W-1:0] a);
        if (got_hit != want_hit) begin
            $display("CHECK FAILED at %t: addr %h hit=%0b, test expects %0b",
                     $time, a, got_hit, want_hit);
            error_count++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        errs = error_count - errors_at_start;
        if (errs == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errs);
        end
        errors_at_start = error_count;
    endtask

    function automatic index_t pick_index(input logic [31:0] r);
        index_t idx;
        case (r[1:0])
            2'd0:    idx = 8'h34;
            2'd1:    idx = 8'h37;
            2'd2:    idx = 8'h80;
            default: idx = 8'hFF;
        endcase
        return idx;
    endfunction

    function automatic tag_t pick_tag(input int k);
        tag_t t;
        case (k)
            0:       t = 20'h00012;
            1:       t = 20'h00100;
            2:       t = 20'h00200;
            3:       t = 20'h00300;
            4:       t = 20'hABCDE;
            default: t = 20'h7F001;
        endcase
        return t;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // memory responder
    //////////////////////////////////////////////////////////////////////

    initial begin : memory_responder
        logic [ADDR_W-1:0] line_addr;
        int                delay;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(posedge clk);
            if (rd_req) begin
                line_addr = rd_addr;
                delay     = int'(rand_bits(2));   // 0 to 3 cycles
                repeat (delay) @(posedge clk);
                #1;
                rd_rdy = 1'b1;
                @(posedge clk);
                #1;
                rd_rdy = 1'b0;
                for (int i = 0; i < WORDS_PER_LINE; i++) begin
                    if (rand_bits(1) != 0) begin
                        @(posedge clk);     // gap before the beat
                        #1;
                    end
                    ret_valid = 1'b1;
                    ret_last  = (i == WORDS_PER_LINE - 1);
                    ret_data  = mem_word(line_addr + 4 * i);
                    @(posedge clk);
                    #1;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a request never finished", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] x_addr;
        logic [ADDR_W-1:0] y_addr;
        logic [ADDR_W-1:0] z_addr;
        logic [ADDR_W-1:0] kept [3];
        logic              got_hit;
        int                k;
        $timeformat(-9, 1, " ns", 0);
        hit_success = 1'b1;
        valid       = 1'b0;
        addr        = '0;
        model_reset();
        repeat (8) @(posedge clk);
        #1;
        hit_success = 1'b0;

        a = 32'h0001_2344;
        fetch(a, got_hit);
        expect_outcome(got_hit, 1'b0, a);
        end_test(1, "cold miss");

        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            fetch({a[31:4], 2'(w), 2'b00}, got_hit);
            expect_outcome(got_hit, 1'b1, {a[31:4], 2'(w), 2'b00});
        end
        end_test(2, "hit");

        // three lines in set 0x37
        x_addr = {20'h00100, 8'h37, 4'h0};
        y_addr = {20'h00200, 8'h37, 4'h4};
        z_addr = {20'h00300, 8'h37, 4'h8};
        fetch(x_addr, got_hit);
        fetch(y_addr, got_hit);
        fetch(z_addr, got_hit);
        expect_outcome(got_hit, 1'b0, z_addr);
        fetch(y_addr, got_hit);
        expect_outcome(got_hit, 1'b1, y_addr);
        fetch(x_addr, got_hit);
        expect_outcome(got_hit, 1'b0, x_addr);
        end_test(3, "two-way lru");

        for (int n = 0; n < RANDOM_REQS; n++) begin
            a[11:4]  = pick_index(rand_bits(2));
            k        = int'(rand_bits(3) % 32'd6);
            a[31:12] = pick_tag(k);
            a[3:0]   = {2'(rand_bits(2)), 2'b00};
            fetch(a, got_hit);
        end
        end_test(4, "random run");

        kept[0] = 32'h0001_2340;
        kept[1] = y_addr;
        kept[2] = {20'hABCDE, 8'h80, 4'h8};
        for (int i = 0; i < 3; i++) begin
            fetch(kept[i], got_hit);
        end
        hit_success = 1'b1;     // reset while idle
        repeat (3) @(posedge clk);
        #1;
        hit_success = 1'b0;
        model_reset();
        repeat (10) begin
            @(posedge clk);
            if (rd_req) begin
                $display("CHECK FAILED at %t: rd_req high with no request", $time);
                error_count++;
            end
        end
        #1;
        for (int i = 0; i < 3; i++) begin
            fetch(kept[i], got_hit);
            expect_outcome(got_hit, 1'b0, kept[i]);
        end
        end_test(5, "reset invalidates");

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
